// File: mips_pkg.sv
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // funct field of R-type words
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_OR  = 4'd3;
    localparam logic [3:0] ALU_XOR = 4'd4;
    localparam logic [3:0] ALU_NOR = 4'd5;
    localparam logic [3:0] ALU_SLT = 4'd6;
    localparam logic [3:0] ALU_SLL = 4'd7;
    localparam logic [3:0] ALU_SRL = 4'd8;
    localparam logic [3:0] ALU_LUI = 4'd9;

    localparam logic [1:0] WB_ALU  = 2'd0;
    localparam logic [1:0] WB_MEM  = 2'd1;
    localparam logic [1:0] WB_LINK = 2'd2;

    localparam logic [2:0] PC_SEQ  = 3'd0;
    localparam logic [2:0] PC_BEQ  = 3'd1;
    localparam logic [2:0] PC_BNE  = 3'd2;
    localparam logic [2:0] PC_JUMP = 3'd3;
    localparam logic [2:0] PC_JR   = 3'd4;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_inst_t;

    // one instruction word, read by format
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
        j_inst_t j;
    } inst_u;

endpackage

// File: mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
    input  mips_pkg::inst_u                     inst,
    output logic [mips_pkg::REG_ADDR_W-1:0]     rs_num,
    output logic [mips_pkg::REG_ADDR_W-1:0]     rt_num,
    output logic [mips_pkg::REG_ADDR_W-1:0]     rd_num,
    output logic                                reg_write,
    output logic                                alu_src_shamt,
    output logic                                alu_src_imm,
    output logic                                mem_write,
    output logic                                mem_byte,
    output logic                                halt_req,
    output logic [3:0]                          alu_op,
    output logic [1:0]                          wb_sel,
    output logic [2:0]                          pc_sel,
    output logic [mips_pkg::XLEN-1:0]           imm_ext
);
    import mips_pkg::*;

    logic sign_ext;

    assign rs_num = inst.r.rs;
    assign rt_num = inst.r.rt;

    // R-type writes rd, jal links into r31
    assign rd_num = (inst.r.opcode == OP_RTYPE) ? inst.r.rd :
                    (inst.r.opcode == OP_JAL)   ? 5'd31     : inst.i.rt;

    assign imm_ext = sign_ext ? {{(XLEN-16){inst.i.imm[15]}}, inst.i.imm}
                              : {{(XLEN-16){1'b0}}, inst.i.imm};

    always_comb begin
        // defaults are a nop
        reg_write     = 1'b0;
        alu_src_shamt = 1'b0;
        alu_src_imm   = 1'b0;
        mem_write     = 1'b0;
        mem_byte      = 1'b0;
        halt_req      = 1'b0;
        sign_ext      = 1'b1;
        alu_op        = ALU_ADD;
        wb_sel        = WB_ALU;
        pc_sel        = PC_SEQ;
        case (inst.r.opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                case (inst.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op        = ALU_SLL;
                        alu_src_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        alu_op        = ALU_SRL;
                        alu_src_shamt = 1'b1;
                    end
                    FN_JR: begin
                        reg_write = 1'b0;
                        pc_sel    = PC_JR;
                    end
                    FN_SYSCALL: begin
                        reg_write = 1'b0;
                        halt_req  = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                // logical immediates are zero-extended
                sign_ext    = (inst.i.opcode == OP_ADDIU) || (inst.i.opcode == OP_SLTI);
                case (inst.i.opcode)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LW, OP_LB: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = WB_MEM;
                mem_byte    = (inst.i.opcode == OP_LB);
            end
            OP_SW, OP_SB: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                mem_byte    = (inst.i.opcode == OP_SB);
            end
            // compare by subtraction, next_pc looks at zero
            OP_BEQ: begin
                alu_op = ALU_SUB;
                pc_sel = PC_BEQ;
            end
            OP_BNE: begin
                alu_op = ALU_SUB;
                pc_sel = PC_BNE;
            end
            OP_J: pc_sel = PC_JUMP;
            OP_JAL: begin
                pc_sel    = PC_JUMP;
                reg_write = 1'b1;
                wb_sel    = WB_LINK;
            end
            default: ;
        endcase
    end

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic                                clk,
    input  logic                                rst_b,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     rs_num,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     rt_num,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     rd_num,
    input  logic [mips_pkg::XLEN-1:0]           rd_data,
    input  logic                                rd_we,
    output logic [mips_pkg::XLEN-1:0]           rs_data,
    output logic [mips_pkg::XLEN-1:0]           rt_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [0:(2**REG_ADDR_W)-1];

    // r0 is never written so it keeps its reset value
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_num != '0)) begin
            regs[rd_num] <= rd_data;
        end
    end

    assign rs_data = regs[rs_num];
    assign rt_data = regs[rt_num];

    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_b)
        ((rs_num == '0) |-> (rs_data == '0)) and ((rt_num == '0) |-> (rt_data == '0))
    );

endmodule

// File: mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  logic [mips_pkg::XLEN-1:0]   rs_data,
    input  logic [mips_pkg::XLEN-1:0]   rt_data,
    input  logic [mips_pkg::XLEN-1:0]   imm_ext,
    input  logic [4:0]                  shamt,
    input  logic                        alu_src_shamt,
    input  logic                        alu_src_imm,
    input  logic [3:0]                  alu_op,
    output logic [mips_pkg::XLEN-1:0]   alu_result,
    output logic                        zero
);
    import mips_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;

    // shifts take shamt as A and shift rt
    assign a = alu_src_shamt ? {{(XLEN-5){1'b0}}, shamt} : rs_data;
    assign b = alu_src_imm ? imm_ext : rt_data;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = a + b;
            ALU_SUB: alu_result = a - b;
            ALU_AND: alu_result = a & b;
            ALU_OR:  alu_result = a | b;
            ALU_XOR: alu_result = a ^ b;
            ALU_NOR: alu_result = ~(a | b);
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_SLL: alu_result = b << a[4:0];
            ALU_SRL: alu_result = b >> a[4:0];
            ALU_LUI: alu_result = b << 16;
            default: alu_result = a + b;
        endcase
    end

    assign zero = (alu_result == '0);

endmodule

// File: mips_next_pc.sv
`timescale 1ns/1ps

module mips_next_pc (
    input  logic [mips_pkg::XLEN-1:0]   pc,
    input  logic [mips_pkg::XLEN-1:0]   rs_data,
    input  logic [mips_pkg::XLEN-1:0]   imm_ext,
    input  logic [25:0]                 target,
    input  logic [2:0]                  pc_sel,
    input  logic                        zero,
    output logic [mips_pkg::XLEN-1:0]   next_pc
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jump_target;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[XLEN-3:0], 2'b00};
    // region bits come from the delay slot address
    assign jump_target   = {pc_plus4[XLEN-1:28], target, 2'b00};

    always_comb begin
        case (pc_sel)
            PC_BEQ:  next_pc = zero ? branch_target : pc_plus4;
            PC_BNE:  next_pc = zero ? pc_plus4 : branch_target;
            PC_JUMP: next_pc = jump_target;
            PC_JR:   next_pc = rs_data;
            default: next_pc = pc_plus4;
        endcase
    end

endmodule

// File: mips_result.sv
`timescale 1ns/1ps

module mips_result (
    input  logic [mips_pkg::XLEN-1:0]   alu_result,
    input  logic [mips_pkg::XLEN-1:0]   mem_rdata,
    input  logic [mips_pkg::XLEN-1:0]   rt_data,
    input  logic [mips_pkg::XLEN-1:0]   pc,
    input  logic [1:0]                  wb_sel,
    input  logic                        mem_write,
    input  logic                        mem_byte,
    input  logic                        write_allow,
    output logic [mips_pkg::XLEN-1:0]   rd_data,
    output logic [mips_pkg::XLEN-1:0]   mem_wdata,
    output logic [3:0]                  mem_write_en
);
    import mips_pkg::*;

    logic [1:0]      lane;
    logic [7:0]      load_byte;
    logic [XLEN-1:0] load_val;

    assign lane = alu_result[1:0];

    // big-endian, lane 0 is the top byte
    always_comb begin
        case (lane)
            2'd0:    load_byte = mem_rdata[31:24];
            2'd1:    load_byte = mem_rdata[23:16];
            2'd2:    load_byte = mem_rdata[15:8];
            default: load_byte = mem_rdata[7:0];
        endcase
    end

    assign load_val = mem_byte ? {{(XLEN-8){load_byte[7]}}, load_byte} : mem_rdata;

    // byte store puts the byte on every lane and enables one
    assign mem_wdata = mem_byte ? {4{rt_data[7:0]}} : rt_data;
    assign mem_write_en = !(mem_write && write_allow) ? 4'b0000 :
                          mem_byte                    ? (4'b1000 >> lane) : 4'b1111;

    always_comb begin
        case (wb_sel)
            WB_MEM:  rd_data = load_val;
            WB_LINK: rd_data = pc + 32'd8;
            default: rd_data = alu_result;
        endcase
    end

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                        clk,
    input  logic                        rst_b,
    output logic [mips_pkg::XLEN-1:0]   inst_addr,
    input  mips_pkg::inst_u             inst,
    output logic [mips_pkg::XLEN-1:0]   mem_addr,
    input  logic [mips_pkg::XLEN-1:0]   mem_rdata,
    output logic [mips_pkg::XLEN-1:0]   mem_wdata,
    output logic [3:0]                  mem_write_en,
    output logic                        halted
);
    import mips_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [REG_ADDR_W-1:0] rs_num;
    logic [REG_ADDR_W-1:0] rt_num;
    logic [REG_ADDR_W-1:0] rd_num;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       rd_data;
    logic [XLEN-1:0]       imm_ext;
    logic [XLEN-1:0]       alu_result;
    logic [3:0]            alu_op;
    logic [1:0]            wb_sel;
    logic [2:0]            pc_sel;
    logic                  reg_write;
    logic                  alu_src_shamt;
    logic                  alu_src_imm;
    logic                  mem_write;
    logic                  mem_byte;
    logic                  halt_req;
    logic                  zero;
    logic                  write_allow;

    assign inst_addr   = pc;
    assign mem_addr    = alu_result;
    assign write_allow = !halted;

    // pc holds on syscall so the halt pc is the syscall address
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (!halted && !halt_req) begin
                pc <= next_pc;
            end
            if (halt_req) begin
                halted <= 1'b1;
            end
        end
    end

    mips_decode u_decode (
        .inst          (inst),
        .rs_num        (rs_num),
        .rt_num        (rt_num),
        .rd_num        (rd_num),
        .reg_write     (reg_write),
        .alu_src_shamt (alu_src_shamt),
        .alu_src_imm   (alu_src_imm),
        .mem_write     (mem_write),
        .mem_byte      (mem_byte),
        .halt_req      (halt_req),
        .alu_op        (alu_op),
        .wb_sel        (wb_sel),
        .pc_sel        (pc_sel),
        .imm_ext       (imm_ext)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (rd_num),
        .rd_data (rd_data),
        .rd_we   (reg_write && write_allow),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    mips_alu u_alu (
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .imm_ext       (imm_ext),
        .shamt         (inst.r.shamt),
        .alu_src_shamt (alu_src_shamt),
        .alu_src_imm   (alu_src_imm),
        .alu_op        (alu_op),
        .alu_result    (alu_result),
        .zero          (zero)
    );

    mips_next_pc u_next_pc (
        .pc      (pc),
        .rs_data (rs_data),
        .imm_ext (imm_ext),
        .target  (inst.j.target),
        .pc_sel  (pc_sel),
        .zero    (zero),
        .next_pc (next_pc)
    );

    mips_result u_result (
        .alu_result   (alu_result),
        .mem_rdata    (mem_rdata),
        .rt_data      (rt_data),
        .pc           (pc),
        .wb_sel       (wb_sel),
        .mem_write    (mem_write),
        .mem_byte     (mem_byte),
        .write_allow  (write_allow),
        .rd_data      (rd_data),
        .mem_wdata    (mem_wdata),
        .mem_write_en (mem_write_en)
    );

    // a store never also writes a register
    a_no_store_and_wb: assert property (
        @(posedge clk) disable iff (!rst_b)
        !(mem_write && reg_write)
    );

    // byte stores touch one lane at most
    a_sb_one_lane: assert property (
        @(posedge clk) disable iff (!rst_b)
        (mem_write && mem_byte) |-> $onehot0(mem_write_en)
    );

    // once halted, pc is frozen and memory is left alone
    a_halt_frozen: assert property (
        @(posedge clk) disable iff (!rst_b)
        halted |=> (halted && $stable(pc) && (mem_write_en == 4'b0000))
    );

endmodule

// File: tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 12;
    localparam int HOLD_CYCLES  = 4;
    localparam int ROW_WORDS    = 9;

    logic            clk;
    logic            rst_b;
    logic [XLEN-1:0] inst_addr;
    inst_u           inst;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] mem_wdata;
    logic [3:0]      mem_write_en;
    logic            halted;

    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    logic [3:0]  lanes_seen;
    logic [31:0] lfsr;
    logic        table_ready;
    int          errors;
    int          failed_tests;

    // test table with one entry per row and the program words flattened
    logic [31:0] tbl_prog [$];
    string       tbl_name [$];
    logic [5:0]  tbl_chk [$];
    logic [31:0] tbl_word [$];
    logic [31:0] tbl_pc [$];
    logic [3:0]  tbl_lanes [$];
    logic [31:0] frag [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_core DUT (
        .clk          (clk),
        .rst_b        (rst_b),
        .inst_addr    (inst_addr),
        .inst         (inst),
        .mem_addr     (mem_addr),
        .mem_rdata    (mem_rdata),
        .mem_wdata    (mem_wdata),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    // instruction ROM shows a nop while reset is low
    assign inst      = rst_b ? rom[inst_addr[7:2]] : '0;
    assign mem_rdata = ram[mem_addr[7:2]];

    function automatic logic [31:0] ram_fill(input int i);
        return 32'h1000_0000 + (i * 4);
    endfunction

    // syscall with the address in its code field
    function automatic logic [31:0] rom_fill(input int a);
        return {OP_RTYPE, 20'(a), FN_SYSCALL};
    endfunction

    // byte-enabled big-endian RAM where enable bit 3 is byte 0
    always @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < 64; i++) begin
                ram[6'(i)] <= ram_fill(i);
            end
        end else begin
            if (mem_write_en[3]) ram[mem_addr[7:2]][31:24] <= mem_wdata[31:24];
            if (mem_write_en[2]) ram[mem_addr[7:2]][23:16] <= mem_wdata[23:16];
            if (mem_write_en[1]) ram[mem_addr[7:2]][15:8]  <= mem_wdata[15:8];
            if (mem_write_en[0]) ram[mem_addr[7:2]][7:0]   <= mem_wdata[7:0];
        end
    end

    // every lane enabled during a run
    always @(posedge clk) begin
        if (!rst_b) begin
            lanes_seen <= 4'b0000;
        end else begin
            lanes_seen <= lanes_seen | mem_write_en;
        end
    end

    // galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic inst_u enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] rd, input logic [4:0] sh,
                                    input logic [5:0] fn);
        inst_u w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = sh;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic inst_u enc_i(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        inst_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic inst_u enc_j(input logic [5:0] op, input logic [25:0] target);
        inst_u w;
        w.j.opcode = op;
        w.j.target = target;
        return w;
    endfunction

    // expected values from the MIPS32 definitions
    function automatic logic [31:0] ref_rtype(input logic [5:0] fn, input logic [31:0] s,
                                              input logic [31:0] t, input logic [4:0] sh);
        case (fn)
            FN_ADDU: return s + t;
            FN_SUBU: return s - t;
            FN_AND:  return s & t;
            FN_OR:   return s | t;
            FN_XOR:  return s ^ t;
            FN_NOR:  return ~(s | t);
            FN_SLT:  return ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
            FN_SLL:  return t << sh;
            FN_SRL:  return t >> sh;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] ref_itype(input logic [5:0] op, input logic [31:0] s,
                                              input logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        sx = {{16{imm[15]}}, imm};
        zx = {16'h0000, imm};
        case (op)
            OP_ADDIU: return s + sx;
            OP_SLTI:  return ($signed(s) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_ANDI:  return s & zx;
            OP_ORI:   return s | zx;
            OP_XORI:  return s ^ zx;
            OP_LUI:   return {imm, 16'h0000};
            default:  return 32'd0;
        endcase
    endfunction

    // lane 0 is the most significant byte
    function automatic logic [31:0] put_byte(input logic [31:0] word, input int lane,
                                             input logic [7:0] b);
        int sh;
        sh = 8 * (3 - lane);
        return (word & ~(32'h0000_00ff << sh)) | ({24'h000000, b} << sh);
    endfunction

    task automatic push(input inst_u w);
        frag.push_back(w);
    endtask

    task automatic load_const(input logic [4:0] r, input logic [31:0] v);
        push(enc_i(OP_LUI, 5'd0, r, v[31:16]));
        push(enc_i(OP_ORI, r, r, v[15:0]));
    endtask

    // closes the fragment with a syscall and files the row
    task automatic end_row(input string name, input int chk, input logic [31:0] word,
                           input logic [31:0] pc, input logic [3:0] lanes);
        push(enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL));
        for (int k = 0; k < ROW_WORDS; k++) begin
            tbl_prog.push_back((k < frag.size()) ? frag[k] : rom_fill(k));
        end
        tbl_name.push_back(name);
        tbl_chk.push_back(6'(chk));
        tbl_word.push_back(word);
        tbl_pc.push_back(pc);
        tbl_lanes.push_back(lanes);
        frag.delete();
    endtask

    task automatic build_table();
        logic [5:0]  r_fns [0:8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                     FN_NOR, FN_SLT, FN_SLL, FN_SRL};
        string       r_names [0:8] = '{"addu", "subu", "and", "or", "xor",
                                       "nor", "slt", "sll", "srl"};
        logic [5:0]  i_ops [0:5] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI};
        string       i_names [0:5] = '{"addiu", "andi", "ori", "xori", "slti", "lui"};
        logic [5:0]  fn;
        logic [5:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [4:0]  sh;
        logic        taken;
        int          chk;
        int          src;
        int          lane;

        end_row("lone syscall", 3, ram_fill(3), 32'd0, 4'b0000);

        for (int k = 0; k < 9; k++) begin
            fn  = r_fns[4'(k)];
            a   = rand_bits(32);
            b   = rand_bits(32);
            sh  = (fn == FN_SLL || fn == FN_SRL) ? 5'(rand_bits(5)) : 5'd0;
            chk = 8 + tbl_name.size();
            load_const(5'd1, a);
            load_const(5'd2, b);
            push(enc_r(5'd1, 5'd2, 5'd3, sh, fn));
            push(enc_i(OP_SW, 5'd0, 5'd3, 16'(chk * 4)));
            end_row(r_names[4'(k)], chk, ref_rtype(fn, a, b, sh), 4 * frag.size(), 4'b1111);
        end

        for (int k = 0; k < 6; k++) begin
            op  = i_ops[3'(k)];
            a   = rand_bits(32);
            imm = 16'(rand_bits(16));
            chk = 8 + tbl_name.size();
            load_const(5'd1, a);
            push(enc_i(op, 5'd1, 5'd3, imm));
            push(enc_i(OP_SW, 5'd0, 5'd3, 16'(chk * 4)));
            end_row(i_names[3'(k)], chk, ref_itype(op, a, imm), 4 * frag.size(), 4'b1111);
        end

        // sb to every lane of a fresh word
        for (lane = 0; lane < 4; lane++) begin
            a   = rand_bits(32);
            chk = 8 + tbl_name.size();
            load_const(5'd1, a);
            push(enc_i(OP_SB, 5'd0, 5'd1, 16'(chk * 4 + lane)));
            end_row($sformatf("sb lane %0d", lane), chk, put_byte(ram_fill(chk), lane, a[7:0]),
                    4 * frag.size(), 4'b0001 << (3 - lane));
        end

        // negative byte goes in with sb, back with lb, out with sw
        a    = rand_bits(32) | 32'h0000_0080;
        lane = int'(rand_bits(2));
        chk  = 8 + tbl_name.size();
        src  = chk + 20;
        load_const(5'd1, a);
        push(enc_i(OP_SB, 5'd0, 5'd1, 16'(src * 4 + lane)));
        push(enc_i(OP_LB, 5'd0, 5'd2, 16'(src * 4 + lane)));
        push(enc_i(OP_SW, 5'd0, 5'd2, 16'(chk * 4)));
        end_row("lb sign", chk, {{24{a[7]}}, a[7:0]}, 4 * frag.size(), 4'b1111);

        chk = 8 + tbl_name.size();
        src = chk + 20;
        push(enc_i(OP_LW, 5'd0, 5'd2, 16'(src * 4)));
        push(enc_i(OP_SW, 5'd0, 5'd2, 16'(chk * 4)));
        end_row("lw copy", chk, ram_fill(src), 4 * frag.size(), 4'b1111);

        // taken path lands on word 6 and the other one jumps over it to word 7
        for (int k = 0; k < 4; k++) begin
            op    = (k < 2) ? OP_BEQ : OP_BNE;
            imm   = 16'(rand_bits(16));
            b     = (k % 2 == 0) ? {16'h0000, imm} : {16'h0000, imm ^ {15'(rand_bits(15)), 1'b1}};
            taken = (op == OP_BEQ) == (k % 2 == 0);
            chk   = 8 + tbl_name.size();
            push(enc_i(OP_ORI, 5'd0, 5'd1, imm));
            push(enc_i(OP_ORI, 5'd0, 5'd2, b[15:0]));
            push(enc_i(op, 5'd1, 5'd2, 16'd3));
            push(enc_i(OP_ORI, 5'd0, 5'd3, 16'h0111));
            push(enc_j(OP_J, 26'd7));
            push(enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL));
            push(enc_i(OP_ORI, 5'd0, 5'd3, 16'h0222));
            push(enc_i(OP_SW, 5'd0, 5'd3, 16'(chk * 4)));
            end_row($sformatf("%s %s", (op == OP_BEQ) ? "beq" : "bne",
                              (k % 2 == 0) ? "equal" : "differ"),
                    chk, taken ? 32'h0000_0222 : 32'h0000_0111, 32'd32, 4'b1111);
        end

        // jal at word 1 links to word 3 and the subroutine sits at word 5
        chk = 8 + tbl_name.size();
        push(enc_i(OP_ORI, 5'd0, 5'd4, 16'h0001));
        push(enc_j(OP_JAL, 26'd5));
        push(enc_i(OP_ORI, 5'd0, 5'd3, 16'h0333));
        push(enc_i(OP_SW, 5'd0, 5'd31, 16'(chk * 4)));
        push(enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL));
        push(enc_r(5'd31, 5'd0, 5'd0, 5'd0, FN_JR));
        end_row("jal jr", chk, 32'd4 + 32'd8, 32'd16, 4'b1111);

        chk = 8 + tbl_name.size();
        load_const(5'd1, rand_bits(32));
        push(enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL));
        push(enc_i(OP_SW, 5'd0, 5'd1, 16'(chk * 4)));
        end_row("store after halt", chk, ram_fill(chk), 32'd8, 4'b0000);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: address %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_lanes(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: lanes %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        int          cycles;
        int          errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        rst_b = 1'b0;
        for (int k = 0; k < 64; k++) begin
            rom[6'(k)] = (k < ROW_WORDS) ? tbl_prog[r * ROW_WORDS + k] : rom_fill(k);
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_pc("inst_addr in reset", inst_addr, 32'd0);
        check_lanes("mem_write_en in reset", mem_write_en, 4'b0000);
        check_flag("halted in reset", halted, 1'b0);
        @(posedge clk);
        #1;
        rst_b = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!halted && cycles < RUN_CYCLES);
        if (!halted) begin
            $display("test %0d %s: DUT never halted within %0d cycles",
                     r, tbl_name[r], RUN_CYCLES);
            errors++;
        end else begin
            check_pc("inst_addr at halt", inst_addr, tbl_pc[r]);
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                check_pc("inst_addr while halted", inst_addr, tbl_pc[r]);
                check_flag("halted while stopped", halted, 1'b1);
            end
            check_word("ram word", ram[tbl_chk[r]], tbl_word[r]);
            check_lanes("mem_write_en seen", lanes_seen, tbl_lanes[r]);
        end
        if (errors == errs_before) begin
            $display("test %0d %s: ok", r, tbl_name[r]);
        end else begin
            $display("test %0d %s: failed", r, tbl_name[r]);
            failed_tests++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_b        = 1'b0;
        lfsr         = 32'h5f7;
        errors       = 0;
        failed_tests = 0;
        table_ready  = 1'b0;
        for (int k = 0; k < 64; k++) begin
            rom[6'(k)] = rom_fill(k);
        end
        build_table();
        table_ready = 1'b1;
        for (int r = 0; r < tbl_name.size(); r++) begin
            run_row(r);
        end
        $display("%0d tests, %0d failed, %0d errors", tbl_name.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // per row the reset, the run budget, the hold check and some margin
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (tbl_name.size() * (RESET_CYCLES + RUN_CYCLES + HOLD_CYCLES + 2) + 8)
                   * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog: DUT never halted, run stopped after %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: list.f
mips_pkg.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_next_pc.sv
mips_result.sv
mips_core.sv
tb_mips_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module tb_mips_core -o tb_mips_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mips_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
